//--- hw/nes_pkg.sv
/*
 * Shared widths, iNES header constants and load addresses for the cartridge loader.
 * Memory is a single 22-bit byte-wide space. PRG loads from 0, CHR from the upper half.
 */
package nes_pkg;

	localparam int addr_width = 22;

	typedef logic [7:0] byte_t;
	typedef logic [addr_width-1:0] mem_addr_t;

	// CHR data goes to the upper half of memory
	localparam mem_addr_t chr_base = {1'b1, {(addr_width - 1){1'b0}}};

	// "NES" followed by MS-DOS end of file
	localparam byte_t ines_magic0 = 8'h4E;
	localparam byte_t ines_magic1 = 8'h45;
	localparam byte_t ines_magic2 = 8'h53;
	localparam byte_t ines_magic3 = 8'h1A;

	localparam int header_len = 16;

	localparam logic [7:0] download_reset_cycles = 8'd255;  // Console hold after a load
	localparam int ce_divide = 4;                            // Console runs every 4th cycle

	// Cartridge description word handed to the console mappers
	typedef struct packed {
		logic [6:0] reserved;
		byte_t      submapper;    // NES 2.0 only
		logic       four_screen;
		logic       chr_ram;      // No CHR ROM in the image
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		byte_t      mapper;
	} mapper_flags_t;

endpackage

//--- hw/ines_header.sv
/*
 * Holds the 16 iNES header bytes and decodes them into the mapper-flags word.
 * header_ok only looks at bytes 0..3 and 6, so it is valid when byte 15 arrives.
 * Images with a trainer are rejected.
 */
`timescale 1ns/1ps

module ines_header (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  hdr_wr,
	input  logic [3:0]            hdr_index,
	input  nes_pkg::byte_t        hdr_data,
	input  logic                  invert_mirroring,
	output logic                  header_ok,
	output nes_pkg::byte_t        prg_pages,
	output nes_pkg::byte_t        chr_pages,
	output nes_pkg::mapper_flags_t flags
);

	nes_pkg::byte_t hdr [nes_pkg::header_len];
	logic is_nes20;
	logic is_dirty;

	// Page count to size code: 1 or fewer is 0, each doubling adds one
	function automatic logic [2:0] size_code(input nes_pkg::byte_t pages);
		logic [2:0] code;
		code = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (pages <= (9'd1 << i))
				code = 3'(i);
		end
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < nes_pkg::header_len; i++)
				hdr[i] <= '0;
		end else if (hdr_wr) begin
			hdr[hdr_index] <= hdr_data;
		end
	end

	assign header_ok = (hdr[0] == nes_pkg::ines_magic0) && (hdr[1] == nes_pkg::ines_magic1) &&
		(hdr[2] == nes_pkg::ines_magic2) && (hdr[3] == nes_pkg::ines_magic3) &&
		!hdr[6][2];  // Trainer not supported

	assign prg_pages = hdr[4];
	assign chr_pages = hdr[5];

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Old dumps often carry junk in the tail bytes
	assign is_dirty = !is_nes20 && ((hdr[9][7:1] != '0) ||
		(|{hdr[10], hdr[11], hdr[12], hdr[13], hdr[14], hdr[15]}));

	always_comb begin
		flags.reserved    = '0;
		flags.submapper   = is_nes20 ? hdr[8] : 8'h00;
		flags.four_screen = hdr[6][3];
		flags.chr_ram     = (hdr[5] == 8'h00);
		flags.mirroring   = hdr[6][0] ^ invert_mirroring;
		flags.chr_size    = size_code(hdr[5]);
		flags.prg_size    = size_code(hdr[4]);
		flags.mapper      = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
	end

endmodule

//--- hw/rom_loader.sv
/*
 * Steps an iNES byte stream through header, PRG and CHR and issues one write per data byte.
 * Bytes are taken only while dl_active is high; extra bytes after the image are ignored.
 * Error and done hold until the next reset, which restarts at the header.
 */
`timescale 1ns/1ps

module rom_loader #(
	parameter int prg_page_bits = 14,  // log2 of bytes per PRG page
	parameter int chr_page_bits = 13   // log2 of bytes per CHR page
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               dl_active,
	input  logic               dl_wr,
	input  nes_pkg::byte_t     dl_data,
	input  logic               header_ok,
	input  nes_pkg::byte_t     prg_pages,
	input  nes_pkg::byte_t     chr_pages,
	output logic               hdr_wr,
	output logic [3:0]         hdr_index,
	output nes_pkg::mem_addr_t ld_addr,
	output nes_pkg::byte_t     ld_data,
	output logic               ld_we,
	output logic               busy,
	output logic               done,
	output logic               error
);

	typedef enum logic [2:0] {
		st_header,
		st_prg,
		st_chr,
		st_error,
		st_done
	} state_t;

	state_t state;
	logic [3:0] hdr_ctr;
	nes_pkg::mem_addr_t addr;
	nes_pkg::mem_addr_t bytes_left;
	nes_pkg::mem_addr_t prg_bytes;
	nes_pkg::mem_addr_t chr_bytes;
	logic byte_in;

	assign byte_in = dl_wr && dl_active;
	assign prg_bytes = nes_pkg::mem_addr_t'(prg_pages) << prg_page_bits;
	assign chr_bytes = nes_pkg::mem_addr_t'(chr_pages) << chr_page_bits;

	assign hdr_wr = byte_in && (state == st_header);
	assign hdr_index = hdr_ctr;
	assign ld_addr = addr;
	assign ld_data = dl_data;
	assign ld_we = byte_in && ((state == st_prg) || (state == st_chr));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_header;
			hdr_ctr <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			case (state)
			st_header: begin
				if (hdr_wr) begin
					hdr_ctr <= hdr_ctr + 4'd1;
					if (hdr_ctr == 4'(nes_pkg::header_len - 1)) begin
						if (!header_ok) begin
							state <= st_error;
							error <= 1'b1;
							done <= 1'b1;
						end else if (prg_bytes != '0) begin
							state <= st_prg;
							addr <= '0;
							bytes_left <= prg_bytes;
							busy <= 1'b1;
						end else if (chr_bytes != '0) begin
							state <= st_chr;
							addr <= nes_pkg::chr_base;
							bytes_left <= chr_bytes;
							busy <= 1'b1;
						end else begin
							state <= st_done;  // Header only, nothing to load
							done <= 1'b1;
						end
					end
				end
			end
			st_prg, st_chr: begin
				if (ld_we) begin
					addr <= addr + 1'b1;
					bytes_left <= bytes_left - 1'b1;
					if (bytes_left == nes_pkg::mem_addr_t'(1)) begin
						if ((state == st_prg) && (chr_bytes != '0)) begin
							state <= st_chr;
							addr <= nes_pkg::chr_base;
							bytes_left <= chr_bytes;
						end else begin
							state <= st_done;
							busy <= 1'b0;
							done <= 1'b1;
						end
					end
				end
			end
			default: ;  // Error and done wait for reset
			endcase
		end
	end

endmodule

//--- hw/mem_arbiter.sv
/*
 * Shares one memory bus between the ROM loader and the console.
 * A loader write is held and issued as a one-cycle mem_we right after the next console slot.
 * The loader keeps the bus until its last held write has gone out.
 */
`timescale 1ns/1ps

module mem_arbiter (
	input  logic               clk,
	input  logic               reset,
	input  logic               console_ce,
	input  logic               loading,
	input  nes_pkg::mem_addr_t ld_addr,
	input  nes_pkg::byte_t     ld_data,
	input  logic               ld_we,
	input  nes_pkg::mem_addr_t cpu_addr,
	input  nes_pkg::byte_t     cpu_wdata,
	input  logic               cpu_we,
	input  logic               cpu_rd,
	output nes_pkg::mem_addr_t mem_addr,
	output nes_pkg::byte_t     mem_wdata,
	output logic               mem_we,
	output logic               mem_rd
);

	logic pending;
	nes_pkg::mem_addr_t pend_addr;
	nes_pkg::byte_t pend_data;
	logic stage_we;
	nes_pkg::mem_addr_t stage_addr;
	nes_pkg::byte_t stage_data;
	logic ld_own;

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
			stage_we <= 1'b0;
		end else begin
			stage_we <= console_ce && pending;
			if (console_ce)
				pending <= 1'b0;
			if (ld_we)
				pending <= 1'b1;  // A new write wins over the release
		end
	end

	// Separate stage so a new capture cannot disturb the write going out
	always_ff @(posedge clk) begin
		if (ld_we) begin
			pend_addr <= ld_addr;
			pend_data <= ld_data;
		end
		if (console_ce && pending) begin
			stage_addr <= pend_addr;
			stage_data <= pend_data;
		end
	end

	assign ld_own = loading || pending || stage_we;

	assign mem_addr  = ld_own ? stage_addr : cpu_addr;
	assign mem_wdata = ld_own ? stage_data : cpu_wdata;
	assign mem_we    = ld_own ? stage_we : cpu_we;
	assign mem_rd    = ld_own ? 1'b0 : cpu_rd;

endmodule

//--- hw/console_ctrl.sv
/*
 * Console clock enable, reset sequencing around downloads and the mapper-flags latch.
 * A failed load keeps the console in reset until the next download starts.
 */
`timescale 1ns/1ps

module console_ctrl (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   busy,
	input  logic                   done,
	input  logic                   error,
	input  logic                   host_reset,
	input  nes_pkg::mapper_flags_t flags,
	output logic                   console_ce,
	output logic                   console_reset,
	output logic                   loader_reset,
	output logic                   loading,
	output nes_pkg::mapper_flags_t mapper_flags
);

	logic [1:0] ce_cnt;
	logic started;   // Seen a download since power-up
	logic failed;
	logic [7:0] dl_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			ce_cnt <= '0;
			started <= 1'b0;
			failed <= 1'b0;
			dl_cnt <= '0;
		end else begin
			ce_cnt <= ce_cnt + 2'd1;
			if (dl_active)
				started <= 1'b1;
			if (dl_active)
				failed <= 1'b0;
			else if (error)
				failed <= 1'b1;
			if (dl_active)
				dl_cnt <= nes_pkg::download_reset_cycles;
			else if (!busy && (dl_cnt != '0))
				dl_cnt <= dl_cnt - 8'd1;  // Starts once the loader has let go
		end
	end

	always_ff @(posedge clk) begin
		if (done)
			mapper_flags <= flags;
	end

	assign console_ce = (ce_cnt == 2'(nes_pkg::ce_divide - 1));
	assign console_reset = !started || dl_active || (dl_cnt != '0) || error || failed ||
		host_reset;
	assign loader_reset = reset || ((dl_cnt == '0) && !dl_active);  // Idle loader sits at header
	assign loading = dl_active || busy;

endmodule

//--- hw/joypad_port.sv
/*
 * One controller serial port. Buttons load on strobe and shift out LSB first.
 * Each falling edge of ser_clk shifts in a 0.
 */
`timescale 1ns/1ps

module joypad_port (
	input  logic           clk,
	input  logic           reset,
	input  logic           strobe,
	input  logic           ser_clk,
	input  nes_pkg::byte_t buttons,
	output logic           ser_data
);

	nes_pkg::byte_t shift;
	logic ser_clk_d;

	always_ff @(posedge clk) begin
		if (reset) begin
			shift <= '0;
			ser_clk_d <= 1'b0;
		end else begin
			ser_clk_d <= ser_clk;
			if (strobe)
				shift <= buttons;
			if (ser_clk_d && !ser_clk)
				shift <= {1'b0, shift[7:1]};  // Falling edge
		end
	end

	assign ser_data = shift[0];

endmodule

//--- hw/nes_loader_top.sv
/*
 * Cartridge-loading side of the console host: iNES loader, bus arbiter, reset control
 * and two controller ports. Host button words arrive already in console bit order.
 * The host must pace dl_wr to at most one strobe every four cycles.
 */
`timescale 1ns/1ps

module nes_loader_top #(
	parameter int prg_page_bits = 14,
	parameter int chr_page_bits = 13
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  nes_pkg::byte_t         dl_data,
	input  logic                   invert_mirroring,
	input  logic                   host_reset,
	input  nes_pkg::mem_addr_t     cpu_addr,
	input  nes_pkg::byte_t         cpu_wdata,
	input  logic                   cpu_we,
	input  logic                   cpu_rd,
	input  logic                   joy_strobe,
	input  logic [1:0]             joy_clk,
	input  nes_pkg::byte_t         joy_a,
	input  nes_pkg::byte_t         joy_b,
	input  logic                   joy_swap,
	output nes_pkg::mem_addr_t     mem_addr,
	output nes_pkg::byte_t         mem_wdata,
	output logic                   mem_we,
	output logic                   mem_rd,
	output logic                   console_ce,
	output logic                   console_reset,
	output nes_pkg::mapper_flags_t mapper_flags,
	output logic [1:0]             joy_data
);

	logic hdr_wr;
	logic [3:0] hdr_index;
	logic header_ok;
	nes_pkg::byte_t prg_pages;
	nes_pkg::byte_t chr_pages;
	nes_pkg::mapper_flags_t flags;
	nes_pkg::mem_addr_t ld_addr;
	nes_pkg::byte_t ld_data;
	logic ld_we;
	logic busy;
	logic done;
	logic error;
	logic loader_reset;
	logic loading;
	nes_pkg::byte_t pad0_buttons;
	nes_pkg::byte_t pad1_buttons;

	ines_header ines_header_i (
		.clk(clk),
		.reset(reset),
		.hdr_wr(hdr_wr),
		.hdr_index(hdr_index),
		.hdr_data(dl_data),
		.invert_mirroring(invert_mirroring),
		.header_ok(header_ok),
		.prg_pages(prg_pages),
		.chr_pages(chr_pages),
		.flags(flags)
	);

	rom_loader #(
		.prg_page_bits(prg_page_bits),
		.chr_page_bits(chr_page_bits)
	) rom_loader_i (
		.clk(clk),
		.reset(loader_reset),
		.dl_active(dl_active),
		.dl_wr(dl_wr),
		.dl_data(dl_data),
		.header_ok(header_ok),
		.prg_pages(prg_pages),
		.chr_pages(chr_pages),
		.hdr_wr(hdr_wr),
		.hdr_index(hdr_index),
		.ld_addr(ld_addr),
		.ld_data(ld_data),
		.ld_we(ld_we),
		.busy(busy),
		.done(done),
		.error(error)
	);

	mem_arbiter mem_arbiter_i (
		.clk(clk),
		.reset(reset),
		.console_ce(console_ce),
		.loading(loading),
		.ld_addr(ld_addr),
		.ld_data(ld_data),
		.ld_we(ld_we),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_we(cpu_we),
		.cpu_rd(cpu_rd),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_we(mem_we),
		.mem_rd(mem_rd)
	);

	console_ctrl console_ctrl_i (
		.clk(clk),
		.reset(reset),
		.dl_active(dl_active),
		.busy(busy),
		.done(done),
		.error(error),
		.host_reset(host_reset),
		.flags(flags),
		.console_ce(console_ce),
		.console_reset(console_reset),
		.loader_reset(loader_reset),
		.loading(loading),
		.mapper_flags(mapper_flags)
	);

	// Player swap
	assign pad0_buttons = joy_swap ? joy_b : joy_a;
	assign pad1_buttons = joy_swap ? joy_a : joy_b;

	joypad_port joypad_port0_i (
		.clk(clk),
		.reset(reset),
		.strobe(joy_strobe),
		.ser_clk(joy_clk[0]),
		.buttons(pad0_buttons),
		.ser_data(joy_data[0])
	);

	joypad_port joypad_port1_i (
		.clk(clk),
		.reset(reset),
		.strobe(joy_strobe),
		.ser_clk(joy_clk[1]),
		.buttons(pad1_buttons),
		.ser_data(joy_data[1])
	);

endmodule

//--- dv/tb_nes_loader.sv
/*
 * Testbench for nes_loader_top with 16-byte PRG pages and 8-byte CHR pages.
 * Images, expected flags and joypad words come from dv/nes_vectors.txt.
 * Stops at the first mismatch.
 */
`timescale 1ns/1ps

module tb_nes_loader;

	localparam int prg_page_bits = 4;
	localparam int chr_page_bits = 3;
	localparam int clk_period = 10;
	localparam int image_len = 40;     // 16 header + 16 PRG + 8 CHR
	localparam int vec_len = 86;
	localparam int total_bytes = 3 * image_len;
	localparam int watchdog_cycles = total_bytes * 8 + 2000;

	logic clk;
	logic reset;
	logic dl_active;
	logic dl_wr;
	nes_pkg::byte_t dl_data;
	logic invert_mirroring;
	logic host_reset;
	nes_pkg::mem_addr_t cpu_addr;
	nes_pkg::byte_t cpu_wdata;
	logic cpu_we;
	logic cpu_rd;
	logic joy_strobe;
	logic [1:0] joy_clk;
	nes_pkg::byte_t joy_a;
	nes_pkg::byte_t joy_b;
	logic joy_swap;
	nes_pkg::mem_addr_t mem_addr;
	nes_pkg::byte_t mem_wdata;
	logic mem_we;
	logic mem_rd;
	logic console_ce;
	logic console_reset;
	nes_pkg::mapper_flags_t mapper_flags;
	logic [1:0] joy_data;

	nes_pkg::byte_t vec [0:vec_len-1];
	nes_pkg::mem_addr_t exp_addr_q[$];
	nes_pkg::byte_t exp_data_q[$];
	logic watch_writes;
	logic [31:0] lcg_state;

	nes_loader_top #(
		.prg_page_bits(prg_page_bits),
		.chr_page_bits(chr_page_bits)
	) nes_loader_top_i (
		.clk(clk),
		.reset(reset),
		.dl_active(dl_active),
		.dl_wr(dl_wr),
		.dl_data(dl_data),
		.invert_mirroring(invert_mirroring),
		.host_reset(host_reset),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_we(cpu_we),
		.cpu_rd(cpu_rd),
		.joy_strobe(joy_strobe),
		.joy_clk(joy_clk),
		.joy_a(joy_a),
		.joy_b(joy_b),
		.joy_swap(joy_swap),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_we(mem_we),
		.mem_rd(mem_rd),
		.console_ce(console_ce),
		.console_reset(console_reset),
		.mapper_flags(mapper_flags),
		.joy_data(joy_data)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input nes_pkg::byte_t got,
		input nes_pkg::byte_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input nes_pkg::mem_addr_t got,
		input nes_pkg::mem_addr_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flags(input string name, input nes_pkg::mapper_flags_t got,
		input nes_pkg::mapper_flags_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Linear congruential generator for console bus traffic
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Every loader write must match the next queued PRG or CHR byte
	always @(posedge clk) begin
		if (!reset) begin
			if (dl_active)
				check_bit("console_reset", console_reset, 1'b1);
			if (watch_writes && mem_we) begin
				if (exp_addr_q.size() == 0) begin
					$display("Memory write at %0t when no loader write was expected", $time);
					abort_run();
				end
				check_addr("mem_addr", mem_addr, exp_addr_q.pop_front());
				check_byte("mem_wdata", mem_wdata, exp_data_q.pop_front());
			end
		end
	end

	// One strobe every 8 cycles. Data bytes go to PRG from 0, then CHR from chr_base
	task automatic send_image(input int first, input logic expect_writes);
		int prg_bytes;
		int k;
		nes_pkg::mem_addr_t addr;
		prg_bytes = int'(vec[first + 4]) << prg_page_bits;
		@(negedge clk);
		dl_active = 1'b1;
		repeat (4) @(negedge clk);
		for (int i = 0; i < image_len; i++) begin
			k = i - nes_pkg::header_len;
			if (expect_writes && k >= 0) begin
				if (k < prg_bytes)
					addr = nes_pkg::mem_addr_t'(k);
				else
					addr = nes_pkg::chr_base + nes_pkg::mem_addr_t'(k - prg_bytes);
				exp_addr_q.push_back(addr);
				exp_data_q.push_back(vec[first + i]);
			end
			dl_wr = 1'b1;
			dl_data = vec[first + i];
			@(negedge clk);
			dl_wr = 1'b0;
			repeat (7) @(negedge clk);
		end
		dl_active = 1'b0;
	endtask

	// Console reset must hold for the full download reset count, then drop
	task automatic check_reset_release();
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (console_reset && cycles < 400) begin
			cycles++;
			@(posedge clk);
		end
		if (cycles != int'(nes_pkg::download_reset_cycles)) begin
			$display("Console reset released after %0d cycles instead of %0d", cycles,
				nes_pkg::download_reset_cycles);
			abort_run();
		end
	endtask

	task automatic run_valid_image(input logic invert);
		nes_pkg::mapper_flags_t exp_flags;
		exp_flags = {vec[80], vec[81], vec[82], vec[83]};
		if (invert)
			exp_flags.mirroring = !exp_flags.mirroring;  // Only mirroring follows invert
		@(negedge clk);
		invert_mirroring = invert;
		watch_writes = 1'b1;
		send_image(0, 1'b1);
		check_reset_release();
		if (exp_addr_q.size() != 0) begin
			$display("%0d loader writes never reached memory", exp_addr_q.size());
			abort_run();
		end
		watch_writes = 1'b0;
		check_flags("mapper_flags", mapper_flags, exp_flags);
	endtask

	task automatic check_ce_pattern();
		int waited;
		waited = 0;
		while (!console_ce && waited < 8) begin
			waited++;
			@(posedge clk);
		end
		if (!console_ce) begin
			$display("console_ce never went high");
			abort_run();
		end
		for (int i = 1; i <= 16; i++) begin
			@(posedge clk);
			check_bit("console_ce", console_ce, (i % 4) == 0);
		end
	endtask

	task automatic check_passthrough();
		nes_pkg::mem_addr_t addr;
		nes_pkg::byte_t data;
		logic we;
		logic rd;
		logic [31:0] rnd;
		for (int i = 0; i < 8; i++) begin
			addr = nes_pkg::mem_addr_t'(next_random());
			data = nes_pkg::byte_t'(next_random());
			rnd = next_random();
			we = rnd[16];
			rnd = next_random();
			rd = rnd[16];
			@(negedge clk);
			cpu_addr = addr;
			cpu_wdata = data;
			cpu_we = we;
			cpu_rd = rd;
			@(posedge clk);
			check_addr("mem_addr", mem_addr, addr);
			check_byte("mem_wdata", mem_wdata, data);
			check_bit("mem_we", mem_we, we);
			check_bit("mem_rd", mem_rd, rd);
		end
		@(negedge clk);
		cpu_we = 1'b0;
		cpu_rd = 1'b0;
	endtask

	// Port 0 gets joy_a unless swapped. Bits leave LSB first with zeros behind them
	task automatic check_joypads(input logic swap);
		nes_pkg::byte_t word0;
		nes_pkg::byte_t word1;
		nes_pkg::byte_t exp0;
		nes_pkg::byte_t exp1;
		word0 = swap ? vec[85] : vec[84];
		word1 = swap ? vec[84] : vec[85];
		@(negedge clk);
		joy_a = vec[84];
		joy_b = vec[85];
		joy_swap = swap;
		joy_strobe = 1'b1;
		@(negedge clk);
		joy_strobe = 1'b0;
		for (int i = 0; i < 10; i++) begin
			exp0 = word0 >> i;
			exp1 = word1 >> i;
			@(posedge clk);
			check_bit("joy_data[0]", joy_data[0], exp0[0]);
			check_bit("joy_data[1]", joy_data[1], exp1[0]);
			@(negedge clk);
			joy_clk = 2'b11;
			@(negedge clk);
			joy_clk = 2'b00;
			@(negedge clk);
		end
	endtask

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Timeout after %0d cycles, the test sequence did not complete",
			watchdog_cycles);
		abort_run();
	end

	initial begin
		reset = 1'b1;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_data = '0;
		invert_mirroring = 1'b0;
		host_reset = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_we = 1'b0;
		cpu_rd = 1'b0;
		joy_strobe = 1'b0;
		joy_clk = 2'b00;
		joy_a = '0;
		joy_b = '0;
		joy_swap = 1'b0;
		watch_writes = 1'b0;
		lcg_state = 32'd16;
		$readmemh("dv/nes_vectors.txt", vec);
		if ($isunknown(vec[vec_len - 1])) begin
			$display("The vectors file could not be read completely");
			abort_run();
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// Console stays in reset until the first download
		repeat (16) begin
			@(posedge clk);
			check_bit("console_reset", console_reset, 1'b1);
			check_bit("mem_we", mem_we, 1'b0);
			check_bit("joy_data[0]", joy_data[0], 1'b0);
			check_bit("joy_data[1]", joy_data[1], 1'b0);
		end

		run_valid_image(1'b0);
		check_ce_pattern();
		check_passthrough();
		run_valid_image(1'b1);

		// Bad signature gives no writes and the console stays held
		@(negedge clk);
		invert_mirroring = 1'b0;
		watch_writes = 1'b1;
		send_image(image_len, 1'b0);
		repeat (300) begin
			@(posedge clk);
			check_bit("console_reset", console_reset, 1'b1);
		end
		watch_writes = 1'b0;

		check_joypads(1'b0);
		check_joypads(1'b1);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- dv/nes_vectors.txt
// Image bytes, eight per line: 16 header bytes, 16 PRG bytes, 8 CHR bytes
// Then four expected mapper-flags bytes (MSB first) and the two joypad words
// Valid image: 1 PRG page, 1 CHR page, mapper 0x14, NES 2.0, submapper 3, vertical
4E 45 53 1A 01 01 41 18
03 00 00 00 00 00 00 00
10 21 32 43 54 65 76 87
98 A9 BA CB DC ED FE 0F
C3 5A 96 69 3C A5 E1 1E
// Image with a bad signature byte
4E 45 53 1B 01 01 41 18
03 00 00 00 00 00 00 00
11 22 33 44 55 66 77 88
99 AA BB CC DD EE FF 01
02 04 08 10 20 40 80 FF
// Expected mapper flags for the valid image with invert_mirroring low
00 06 40 14
// Joypad words for joy_a and joy_b
A5 3C

//--- flist.f
hw/nes_pkg.sv
hw/ines_header.sv
hw/rom_loader.sv
hw/mem_arbiter.sv
hw/console_ctrl.sv
hw/joypad_port.sv
hw/nes_loader_top.sv
dv/tb_nes_loader.sv
